/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= cp0_tb
FILELIST  ?= cp0_top.f
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* cp0_top.f */
+incdir+rtl
rtl/cp0_pkg.sv
rtl/cp0_timer.sv
rtl/cp0_exc_ctrl.sv
rtl/cp0_read_mux.sv
rtl/cp0_fwd_bypass.sv
rtl/cp0_top.sv
sim/cp0_tb.sv

/* rtl/cp0_exc_ctrl.sv */
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cp0_exc_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  cp0_pkg::cp0_wr_t  wr_i,
    input  cp0_pkg::cp0_exc_t exc_i,
    input  logic [5:0]        int_i,
    output cp0_pkg::word_t    status_o,
    output cp0_pkg::word_t    cause_o,
    output cp0_pkg::word_t    epc_o,
    output cp0_pkg::word_t    badvaddr_o
);

    logic           exc_entry;
    logic           addr_err;
    logic [4:0]     exc_code;
    logic           exc_eret;
    logic           save_epc;
    cp0_pkg::word_t epc_next;

    // classify the incoming exception
    always_comb begin
        exc_entry = 1'b1;
        addr_err  = 1'b0;
        exc_code  = `EXCCODE_INT;
        case (exc_i.exc_type)
            `EXC_INT:  exc_code = `EXCCODE_INT;
            `EXC_ADEL: begin
                exc_code = `EXCCODE_ADEL;
                addr_err = 1'b1;
            end
            `EXC_ADES: begin
                exc_code = `EXCCODE_ADES;
                addr_err = 1'b1;
            end
            `EXC_SYS:  exc_code = `EXCCODE_SYS;
            `EXC_BP:   exc_code = `EXCCODE_BP;
            `EXC_RI:   exc_code = `EXCCODE_RI;
            `EXC_OV:   exc_code = `EXCCODE_OV;
            `EXC_TR:   exc_code = `EXCCODE_TR;
            default:   exc_entry = 1'b0;  // eret or no exception
        endcase
    end

    assign exc_eret = (exc_i.exc_type == `EXC_ERET);

    // nested exceptions keep the first epc, interrupts always overwrite it
    assign save_epc = exc_entry && ((exc_i.exc_type == `EXC_INT) || !status_o[1]);
    assign epc_next = exc_i.in_delay ? exc_i.pc - cp0_pkg::word_t'(4) : exc_i.pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            status_o   <= `STATUS_RESET;
            cause_o    <= '0;
            epc_o      <= '0;
            badvaddr_o <= '0;
        end else begin
            cause_o[15:10] <= int_i;  // hw interrupt pending bits

            if (wr_i.en) begin
                case (wr_i.addr)
                    `CP0_REG_STATUS:   status_o <= wr_i.data;
                    `CP0_REG_EPC:      epc_o <= wr_i.data;
                    `CP0_REG_BADVADDR: badvaddr_o <= wr_i.data;
                    `CP0_REG_CAUSE: begin
                        cause_o[9:8] <= wr_i.data[9:8];  // sw interrupts
                        cause_o[23]  <= wr_i.data[23];
                        cause_o[22]  <= wr_i.data[22];
                    end
                    default: ;
                endcase
            end

            // exception fields land after the write so they take precedence
            if (exc_entry) begin
                if (save_epc) begin
                    epc_o       <= epc_next;
                    cause_o[31] <= exc_i.in_delay;  // bd
                end
                status_o[1]  <= 1'b1;  // exl
                cause_o[6:2] <= exc_code;
                if (addr_err) begin
                    badvaddr_o <= exc_i.bad_vaddr;
                end
            end else if (exc_eret) begin
                status_o[1] <= 1'b0;
            end
        end
    end

endmodule

/* rtl/cp0_fwd_bypass.sv */
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cp0_fwd_bypass (
    input  logic              clk,
    input  logic              rst,
    input  cp0_pkg::stall_t   stall_i,
    input  cp0_pkg::cp0_fwd_t fwd_i [0:`CP0_FWD_STAGES-1],
    input  cp0_pkg::cp0_rd_t  rd_i,
    input  cp0_pkg::word_t    arch_data_i,
    output cp0_pkg::word_t    data_o
);

    cp0_pkg::cp0_fwd_t          buf_q [0:`CP0_FWD_STAGES-1];
    logic [`CP0_FWD_STAGES-1:0] hit;
    logic                       flush;
    logic                       load;

    assign load  = !stall_i[`STALL_CUR];
    // stage stalled while the next one moves on, so its writes are gone
    assign flush = stall_i[`STALL_CUR] && !stall_i[`STALL_NEXT];

    always_ff @(posedge clk) begin
        for (int i = 0; i < `CP0_FWD_STAGES; i++) begin
            if (rst || flush) begin
                buf_q[i].valid <= 1'b0;
            end else if (load) begin
                buf_q[i] <= fwd_i[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `CP0_FWD_STAGES; i++) begin
            hit[i] = buf_q[i].valid
                  && (buf_q[i].addr == rd_i.addr)
                  && (buf_q[i].sel == rd_i.sel);
        end
    end

    // walk oldest to youngest, youngest hit wins
    always_comb begin
        data_o = arch_data_i;
        for (int i = `CP0_FWD_STAGES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                data_o = buf_q[i].data;
            end
        end
    end

endmodule

/* rtl/cp0_pkg.sv */
`include "cp0_settings.svh"

package cp0_pkg;

    typedef logic [`CP0_DATA_W-1:0]  word_t;
    typedef logic [`CP0_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`CP0_SEL_W-1:0]   reg_sel_t;
    typedef logic [`CP0_EXC_W-1:0]   exc_type_t;
    typedef logic [`CP0_STALL_W-1:0] stall_t;

    // move-to write from the pipeline
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        reg_sel_t  sel;
        word_t     data;
    } cp0_wr_t;

    typedef struct packed {
        reg_addr_t addr;
        reg_sel_t  sel;
    } cp0_rd_t;

    typedef struct packed {
        exc_type_t exc_type;
        word_t     pc;
        word_t     bad_vaddr;
        logic      in_delay;  // faulting instr sits in a delay slot
    } cp0_exc_t;

    // pending cp0 write still in flight
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        reg_sel_t  sel;
        word_t     data;
    } cp0_fwd_t;

endpackage

/* rtl/cp0_read_mux.sv */
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cp0_read_mux (
    input  cp0_pkg::cp0_rd_t rd_i,
    input  cp0_pkg::word_t   badvaddr_i,
    input  cp0_pkg::word_t   count_i,
    input  cp0_pkg::word_t   compare_i,
    input  cp0_pkg::word_t   status_i,
    input  cp0_pkg::word_t   cause_i,
    input  cp0_pkg::word_t   epc_i,
    output cp0_pkg::word_t   rdata_o
);

    always_comb begin
        rdata_o = '0;
        case (rd_i.addr)
            `CP0_REG_BADVADDR: rdata_o = badvaddr_i;
            `CP0_REG_COUNT:    rdata_o = count_i;
            `CP0_REG_COMPARE:  rdata_o = compare_i;
            `CP0_REG_STATUS:   rdata_o = status_i;
            `CP0_REG_CAUSE:    rdata_o = cause_i;
            `CP0_REG_EPC:      rdata_o = epc_i;
            `CP0_REG_PRID:     rdata_o = `PRID_VALUE;
            `CP0_REG_CONFIG: begin
                // only config has more than one select
                case (rd_i.sel)
                    3'd0:    rdata_o = `CONFIG0_VALUE;
                    3'd1:    rdata_o = `CONFIG1_VALUE;
                    default: rdata_o = '0;
                endcase
            end
            default: rdata_o = '0;
        endcase
    end

endmodule

/* rtl/cp0_settings.svh */
`ifndef CP0_SETTINGS_SVH
`define CP0_SETTINGS_SVH

`define CP0_DATA_W        32
`define CP0_ADDR_W        5
`define CP0_SEL_W         3
`define CP0_EXC_W         5
`define CP0_STALL_W       6
`define CP0_FWD_STAGES    4

`define STALL_CUR         3
`define STALL_NEXT        4

`define CP0_REG_BADVADDR  5'd8
`define CP0_REG_COUNT     5'd9
`define CP0_REG_COMPARE   5'd11
`define CP0_REG_STATUS    5'd12
`define CP0_REG_CAUSE     5'd13
`define CP0_REG_EPC       5'd14
`define CP0_REG_PRID      5'd15
`define CP0_REG_CONFIG    5'd16

// exception types as reported by the pipeline
`define EXC_INT           5'd1
`define EXC_ADEL          5'd4
`define EXC_ADES          5'd5
`define EXC_SYS           5'd8
`define EXC_BP            5'd9
`define EXC_RI            5'd10
`define EXC_OV            5'd12
`define EXC_TR            5'd13
`define EXC_ERET          5'd14

// cause[6:2] codes
`define EXCCODE_INT       5'd0
`define EXCCODE_ADEL      5'd4
`define EXCCODE_ADES      5'd5
`define EXCCODE_SYS       5'd8
`define EXCCODE_BP        5'd9
`define EXCCODE_RI        5'd10
`define EXCCODE_OV        5'd12
`define EXCCODE_TR        5'd13

`define STATUS_RESET      32'h1000_0000
`define PRID_VALUE        32'h0000_4220
`define CONFIG0_VALUE     32'h8000_0003
`define CONFIG1_VALUE     32'h0108_4000

`endif

/* rtl/cp0_timer.sv */
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cp0_timer (
    input  logic             clk,
    input  logic             rst,
    input  cp0_pkg::cp0_wr_t wr_i,
    output cp0_pkg::word_t   count_o,
    output cp0_pkg::word_t   compare_o,
    output logic             timer_int_o
);

    logic tick;
    logic wr_count;
    logic wr_compare;

    assign wr_count   = wr_i.en && (wr_i.addr == `CP0_REG_COUNT);
    assign wr_compare = wr_i.en && (wr_i.addr == `CP0_REG_COMPARE);

    // half-rate prescaler
    always_ff @(posedge clk) begin
        if (rst) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_o   <= '0;
            compare_o <= '0;
        end else begin
            if (wr_count) begin
                count_o <= wr_i.data;  // write beats the increment
            end else if (tick) begin
                count_o <= count_o + cp0_pkg::word_t'(1);
            end
            if (wr_compare) begin
                compare_o <= wr_i.data;
            end
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_int_o <= 1'b0;
        end else if ((compare_o != '0) && (count_o == compare_o)) begin
            timer_int_o <= 1'b1;
        end
    end

endmodule

/* rtl/cp0_top.sv */
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cp0_top (
    input  logic              clk,
    input  logic              rst,
    input  cp0_pkg::cp0_wr_t  wr_i,
    input  cp0_pkg::cp0_rd_t  rd_i,
    input  cp0_pkg::cp0_exc_t exc_i,
    input  cp0_pkg::stall_t   stall_i,
    input  logic [5:0]        int_i,
    input  cp0_pkg::cp0_fwd_t fwd_i [0:`CP0_FWD_STAGES-1],
    output cp0_pkg::word_t    data_o,
    output cp0_pkg::word_t    status_o,
    output cp0_pkg::word_t    cause_o,
    output cp0_pkg::word_t    epc_o,
    output cp0_pkg::word_t    count_o,
    output logic              timer_int_o
);

    cp0_pkg::word_t compare;
    cp0_pkg::word_t badvaddr;
    cp0_pkg::word_t arch_data;  // read before forwarding

    cp0_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (wr_i),
        .count_o     (count_o),
        .compare_o   (compare),
        .timer_int_o (timer_int_o)
    );

    cp0_exc_ctrl u_exc_ctrl (
        .clk        (clk),
        .rst        (rst),
        .wr_i       (wr_i),
        .exc_i      (exc_i),
        .int_i      (int_i),
        .status_o   (status_o),
        .cause_o    (cause_o),
        .epc_o      (epc_o),
        .badvaddr_o (badvaddr)
    );

    cp0_read_mux u_read_mux (
        .rd_i       (rd_i),
        .badvaddr_i (badvaddr),
        .count_i    (count_o),
        .compare_i  (compare),
        .status_i   (status_o),
        .cause_i    (cause_o),
        .epc_i      (epc_o),
        .rdata_o    (arch_data)
    );

    cp0_fwd_bypass u_fwd_bypass (
        .clk         (clk),
        .rst         (rst),
        .stall_i     (stall_i),
        .fwd_i       (fwd_i),
        .rd_i        (rd_i),
        .arch_data_i (arch_data),
        .data_o      (data_o)
    );

endmodule

/* sim/cp0_tb.sv */
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cp0_tb;

    typedef struct packed {
        cp0_pkg::word_t                          status;
        cp0_pkg::word_t                          cause;
        cp0_pkg::word_t                          epc;
        cp0_pkg::word_t                          badvaddr;
        cp0_pkg::cp0_fwd_t [`CP0_FWD_STAGES-1:0] bufs;  // index 0 youngest
    } model_t;

    logic              clk;
    logic              rst;
    cp0_pkg::cp0_wr_t  wr;
    cp0_pkg::cp0_rd_t  rd;
    cp0_pkg::cp0_exc_t exc;
    cp0_pkg::stall_t   stall;
    logic [5:0]        ints;
    cp0_pkg::cp0_fwd_t fwd [0:`CP0_FWD_STAGES-1];
    cp0_pkg::word_t    data;
    cp0_pkg::word_t    status;
    cp0_pkg::word_t    cause;
    cp0_pkg::word_t    epc;
    cp0_pkg::word_t    count;
    logic              timer_int;
    model_t            model;
    cp0_pkg::word_t    count_prev;
    logic [31:0]       rng_state = 32'hd64d;
    int                cmp_errors = 0;
    int                cmp_cycles = 0;
    int                dir_errors = 0;

    cp0_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (wr),
        .rd_i        (rd),
        .exc_i       (exc),
        .stall_i     (stall),
        .int_i       (ints),
        .fwd_i       (fwd),
        .data_o      (data),
        .status_o    (status),
        .cause_o     (cause),
        .epc_o       (epc),
        .count_o     (count),
        .timer_int_o (timer_int)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] rand_word();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // six readable registers plus two unused numbers
    function automatic cp0_pkg::reg_addr_t pick_reg(input logic [2:0] r);
        case (r)
            3'd0:    return `CP0_REG_BADVADDR;
            3'd1:    return `CP0_REG_STATUS;
            3'd2:    return `CP0_REG_CAUSE;
            3'd3:    return `CP0_REG_EPC;
            3'd4:    return `CP0_REG_PRID;
            3'd5:    return `CP0_REG_CONFIG;
            3'd6:    return 5'd0;
            default: return 5'd20;
        endcase
    endfunction

    function automatic cp0_pkg::exc_type_t pick_exc(input logic [3:0] r);
        case (r)
            4'd0:       return `EXC_INT;
            4'd1:       return `EXC_ADEL;
            4'd2:       return `EXC_ADES;
            4'd3:       return `EXC_SYS;
            4'd4:       return `EXC_BP;
            4'd5:       return `EXC_RI;
            4'd6:       return `EXC_OV;
            4'd7:       return `EXC_TR;
            4'd8, 4'd9: return `EXC_ERET;
            default:    return 5'd0;  // no exception
        endcase
    endfunction

    function automatic model_t reset_model();
        model_t m;
        m = '0;
        m.status = `STATUS_RESET;
        return m;
    endfunction

    function automatic model_t cp0_model(input model_t m, input cp0_pkg::cp0_wr_t w,
            input cp0_pkg::cp0_exc_t e, input logic [5:0] irq, input cp0_pkg::stall_t st,
            input cp0_pkg::cp0_fwd_t [`CP0_FWD_STAGES-1:0] f);
        model_t     n;
        logic       enters;
        logic [4:0] code;
        n = m;
        n.cause[15:10] = irq;
        if (w.en) begin
            case (w.addr)
                `CP0_REG_STATUS:   n.status = w.data;
                `CP0_REG_EPC:      n.epc = w.data;
                `CP0_REG_BADVADDR: n.badvaddr = w.data;
                `CP0_REG_CAUSE: begin
                    n.cause[9:8]   = w.data[9:8];
                    n.cause[23:22] = w.data[23:22];
                end
                default: ;
            endcase
        end
        enters = 1'b1;
        code   = 5'd0;
        case (e.exc_type)
            `EXC_INT:  code = `EXCCODE_INT;
            `EXC_ADEL: code = `EXCCODE_ADEL;
            `EXC_ADES: code = `EXCCODE_ADES;
            `EXC_SYS:  code = `EXCCODE_SYS;
            `EXC_BP:   code = `EXCCODE_BP;
            `EXC_RI:   code = `EXCCODE_RI;
            `EXC_OV:   code = `EXCCODE_OV;
            `EXC_TR:   code = `EXCCODE_TR;
            default:   enters = 1'b0;
        endcase
        if (enters) begin
            if (e.exc_type == `EXC_INT || !m.status[1]) begin
                n.epc       = e.in_delay ? e.pc - 32'd4 : e.pc;
                n.cause[31] = e.in_delay;
            end
            n.status[1]  = 1'b1;
            n.cause[6:2] = code;
            if (e.exc_type == `EXC_ADEL || e.exc_type == `EXC_ADES) begin
                n.badvaddr = e.bad_vaddr;
            end
        end else if (e.exc_type == `EXC_ERET) begin
            n.status[1] = 1'b0;
        end
        if (!st[`STALL_CUR]) begin
            n.bufs = f;
        end else if (!st[`STALL_NEXT]) begin
            for (int i = 0; i < `CP0_FWD_STAGES; i++) begin
                n.bufs[i].valid = 1'b0;
            end
        end
        return n;
    endfunction

    function automatic cp0_pkg::word_t expected_read(input model_t m, input cp0_pkg::cp0_rd_t r);
        cp0_pkg::word_t w;
        logic           found;
        case (r.addr)
            `CP0_REG_BADVADDR: w = m.badvaddr;
            `CP0_REG_STATUS:   w = m.status;
            `CP0_REG_CAUSE:    w = m.cause;
            `CP0_REG_EPC:      w = m.epc;
            `CP0_REG_PRID:     w = `PRID_VALUE;
            `CP0_REG_CONFIG:   w = (r.sel == 3'd0) ? `CONFIG0_VALUE :
                                   (r.sel == 3'd1) ? `CONFIG1_VALUE : '0;
            default:           w = '0;
        endcase
        found = 1'b0;
        for (int i = 0; i < `CP0_FWD_STAGES; i++) begin
            if (!found && m.bufs[i].valid && m.bufs[i].addr == r.addr
                    && m.bufs[i].sel == r.sel) begin
                w     = m.bufs[i].data;
                found = 1'b1;
            end
        end
        return w;
    endfunction

    function automatic int compare_word(input string name, input cp0_pkg::word_t exp,
            input cp0_pkg::word_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge clk) begin : compare_outputs
        cp0_pkg::cp0_fwd_t [`CP0_FWD_STAGES-1:0] fwd_now;
        for (int i = 0; i < `CP0_FWD_STAGES; i++) begin
            fwd_now[i] = fwd[i];
        end
        if (rst) begin
            model = reset_model();
        end else begin
            model = cp0_model(model, wr, exc, ints, stall, fwd_now);
        end
        #4;  // registers settled, inputs change only at the falling edge
        cmp_cycles = cmp_cycles + 1;
        cmp_errors = cmp_errors + compare_word("status_o", model.status, status);
        cmp_errors = cmp_errors + compare_word("cause_o", model.cause, cause);
        cmp_errors = cmp_errors + compare_word("epc_o", model.epc, epc);
        cmp_errors = cmp_errors + compare_word("data_o", expected_read(model, rd), data);
    end

    task automatic drive_idle();
        wr    = '0;
        exc   = '0;
        stall = '0;
        for (int i = 0; i < `CP0_FWD_STAGES; i++) begin
            fwd[i] = '0;
        end
    endtask

    task automatic step_watch_count();
        @(negedge clk);
        if (count < count_prev) begin
            dir_errors++;
            $display("count went down from %h to %h at %0t", count_prev, count, $time);
        end
        count_prev = count;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        @(negedge clk);
        drive_idle();
        @(negedge clk);
        $display("test %-12s %0d errors", name, cmp_errors + dir_errors - errs_before);
    endtask

    initial begin
        int          base;
        int          n;
        logic [31:0] r;
        rst  = 1'b1;
        rd   = '0;
        ints = '0;
        drive_idle();
        repeat (10) @(negedge clk);
        rst = 1'b0;

        base = cmp_errors + dir_errors;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            rd.addr = (i == 0) ? `CP0_REG_PRID : `CP0_REG_CONFIG;
            rd.sel  = (i == 0) ? 3'd0 : 3'(i - 1);
        end
        finish_test("reset", base);

        base = cmp_errors + dir_errors;
        for (int i = 0; i < 200; i++) begin
            @(negedge clk);
            r       = rand_word();
            wr.en   = r[0];
            wr.addr = pick_reg({1'b0, r[2:1]});
            wr.sel  = 3'd0;
            wr.data = rand_word();
            rd.addr = pick_reg({1'b0, r[4:3]});
            rd.sel  = r[7:5];
        end
        finish_test("write_masks", base);

        base = cmp_errors + dir_errors;
        for (int i = 0; i < 300; i++) begin
            @(negedge clk);
            r             = rand_word();
            exc.exc_type  = pick_exc(r[3:0]);
            exc.in_delay  = r[4];
            exc.pc        = rand_word();
            exc.bad_vaddr = rand_word();
            wr.en         = (r[7:5] == 3'd0);  // now and then a colliding write
            wr.addr       = pick_reg({1'b0, r[9:8]});
            wr.data       = rand_word();
            rd.addr       = pick_reg({1'b0, r[11:10]});
            rd.sel        = 3'd0;
        end
        finish_test("exceptions", base);

        base = cmp_errors + dir_errors;
        rd.addr = `CP0_REG_CAUSE;
        for (int i = 0; i < 100; i++) begin
            @(negedge clk);
            r    = rand_word();
            ints = r[5:0];
        end
        finish_test("interrupts", base);

        base = cmp_errors + dir_errors;
        @(negedge clk);
        rd.addr = `CP0_REG_STATUS;
        wr.en   = 1'b1;
        wr.addr = `CP0_REG_COMPARE;
        wr.data = 32'h0000_2008;
        @(negedge clk);
        wr.addr = `CP0_REG_COUNT;
        wr.data = 32'h0000_2000;
        @(negedge clk);
        wr.en = 1'b0;
        dir_errors = dir_errors + compare_word("count_o", 32'h0000_2000, count);
        if (timer_int !== 1'b0) begin
            dir_errors++;
            $display("timer interrupt already set before count reached compare");
        end
        count_prev = count;
        n = 0;
        while (timer_int !== 1'b1 && n < 64) begin
            step_watch_count();
            n++;
        end
        if (timer_int !== 1'b1) begin
            dir_errors++;
            $display("timer interrupt did not rise within 64 cycles");
        end else if (count < 32'h0000_2008) begin
            dir_errors++;
            $display("timer interrupt rose before count reached compare");
        end
        for (int i = 0; i < 20; i++) begin
            step_watch_count();
            if (timer_int !== 1'b1) begin
                dir_errors++;
                $display("timer interrupt dropped at %0t", $time);
            end
        end
        finish_test("timer", base);

        base = cmp_errors + dir_errors;
        for (int i = 0; i < 300; i++) begin
            @(negedge clk);
            for (int s = 0; s < `CP0_FWD_STAGES; s++) begin
                r            = rand_word();
                fwd[s].valid = r[0];
                fwd[s].addr  = pick_reg(r[3:1]);
                fwd[s].sel   = {2'b00, r[4]};
                fwd[s].data  = rand_word();
            end
            r       = rand_word();
            stall   = r[5:0];
            rd.addr = pick_reg(r[8:6]);
            rd.sel  = {2'b00, r[9]};
        end
        finish_test("forwarding", base);

        $display("%0d compared cycles, %0d compare errors, %0d directed errors",
                 cmp_cycles, cmp_errors, dir_errors);
        if (cmp_errors + dir_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
